// File: design/mips_pkg.sv
package mips_pkg;

    localparam int data_width = 32;
    localparam int regf_width = 5;

    localparam logic [data_width-1:0] reset_pc = 32'hbfc0_0000;

    // Primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;

    // Function codes under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_addu, alu_subu, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_lui
    } alu_op_t;

    typedef struct packed {
        logic [data_width-1:0] pc;
        logic [data_width-1:0] instr;
    } fetch_info_t;

    typedef struct packed {
        logic [data_width-1:0] pc;
        alu_op_t               alu_op;
        logic [regf_width-1:0] rs_regf;
        logic [regf_width-1:0] rt_regf;
        logic [data_width-1:0] rs_data;
        logic [data_width-1:0] rt_data;
        logic [data_width-1:0] imme;
        logic                  sel_imme; // Operand b from imme
        logic [4:0]            shamt;
        logic [regf_width-1:0] rd_regf;
        logic                  wen;
    } exec_info_t;

    typedef struct packed {
        logic [data_width-1:0] pc;
        logic                  wen;
        logic [regf_width-1:0] rd_regf;
        logic [data_width-1:0] result;
    } retire_info_t;

endpackage

// File: design/stage_buffer.sv
`timescale 1ns/1ns

module stage_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     out_ready,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data
);

    // Empty, or the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            instr_valid,
    input  logic [mips_pkg::data_width-1:0] instr_data,
    input  logic                            out_ready,
    output logic                            instr_ready,
    output logic                            out_valid,
    output mips_pkg::fetch_info_t           out_data
);

    import mips_pkg::*;

    logic [data_width-1:0] pc;
    logic [data_width-1:0] clean_instr;
    logic                  accept;

    // Stream passes straight through to the f_d buffer
    assign instr_ready = out_ready;
    assign out_valid   = instr_valid;
    assign accept      = instr_valid && out_ready;

    // Undriven word would poison decode
    assign clean_instr = $isunknown(instr_data) ? '0 : instr_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (accept) begin
            pc <= pc + data_width'(4);
        end
    end

    always_comb begin
        out_data.pc    = pc;
        out_data.instr = clean_instr;
    end

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
    input  mips_pkg::fetch_info_t           in_data,
    input  logic [mips_pkg::data_width-1:0] rs_data,
    input  logic [mips_pkg::data_width-1:0] rt_data,
    output logic [mips_pkg::regf_width-1:0] rs_regf,
    output logic [mips_pkg::regf_width-1:0] rt_regf,
    output mips_pkg::exec_info_t            out_data
);

    import mips_pkg::*;

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [regf_width-1:0] rd_field;
    logic [4:0]            shamt;
    logic [15:0]           imm16;
    logic [data_width-1:0] imme;
    logic [regf_width-1:0] dest;
    logic                  known;
    logic                  r_type;
    alu_op_t               op;

    assign opcode   = in_data.instr[31:26];
    assign rs_regf  = in_data.instr[25:21];
    assign rt_regf  = in_data.instr[20:16];
    assign rd_field = in_data.instr[15:11];
    assign shamt    = in_data.instr[10:6];
    assign funct    = in_data.instr[5:0];
    assign imm16    = in_data.instr[15:0];

    always_comb begin
        op     = alu_addu;
        known  = 1'b1;
        r_type = 1'b0;
        imme   = {16'b0, imm16}; // Zero extend by default
        case (opcode)
            op_special: begin
                r_type = 1'b1;
                case (funct)
                    fn_addu: op = alu_addu;
                    fn_subu: op = alu_subu;
                    fn_and:  op = alu_and;
                    fn_or:   op = alu_or;
                    fn_xor:  op = alu_xor;
                    fn_slt:  op = alu_slt;
                    fn_sll:  op = alu_sll;
                    default: known = 1'b0;
                endcase
            end
            op_addiu: begin
                op   = alu_addu;
                imme = {{16{imm16[15]}}, imm16};
            end
            op_andi: op = alu_and;
            op_ori:  op = alu_or;
            op_lui:  op = alu_lui;
            default: known = 1'b0;
        endcase
    end

    assign dest = r_type ? rd_field : rt_regf;

    always_comb begin
        out_data.pc       = in_data.pc;
        out_data.alu_op   = op;
        out_data.rs_regf  = rs_regf;
        out_data.rt_regf  = rt_regf;
        out_data.rs_data  = rs_data;
        out_data.rt_data  = rt_data;
        out_data.imme     = imme;
        out_data.sel_imme = !r_type;
        out_data.shamt    = shamt;
        out_data.rd_regf  = dest;
        out_data.wen      = known && (dest != '0);
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [mips_pkg::regf_width-1:0] rs_regf,
    input  logic [mips_pkg::regf_width-1:0] rt_regf,
    input  logic                            wen,
    input  logic [mips_pkg::regf_width-1:0] wr_regf,
    input  logic [mips_pkg::data_width-1:0] wr_data,
    output logic [mips_pkg::data_width-1:0] rs_data,
    output logic [mips_pkg::data_width-1:0] rt_data
);

    import mips_pkg::*;

    logic [data_width-1:0] regs [1:31]; // r0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wr_regf != '0) begin
            regs[wr_regf] <= wr_data;
        end
    end

    // Same-cycle write shows through
    assign rs_data = (rs_regf == '0) ? '0 :
                     (wen && wr_regf == rs_regf) ? wr_data : regs[rs_regf];
    assign rt_data = (rt_regf == '0) ? '0 :
                     (wen && wr_regf == rt_regf) ? wr_data : regs[rt_regf];

endmodule

// File: design/forward_unit.sv
`timescale 1ns/1ns

module forward_unit (
    input  logic [mips_pkg::regf_width-1:0] ex_rs_regf,
    input  logic [mips_pkg::regf_width-1:0] ex_rt_regf,
    input  logic [mips_pkg::data_width-1:0] ex_rs_data,
    input  logic [mips_pkg::data_width-1:0] ex_rt_data,
    input  logic                            wb_valid,
    input  logic                            wb_wen,
    input  logic [mips_pkg::regf_width-1:0] wb_regf,
    input  logic [mips_pkg::data_width-1:0] wb_data,
    output logic [mips_pkg::data_width-1:0] rs_value,
    output logic [mips_pkg::data_width-1:0] rt_value
);

    logic wb_live;
    logic fwd_rs;
    logic fwd_rt;

    // Writeback holds a pending register write
    assign wb_live = wb_valid && wb_wen && (wb_regf != '0);

    assign fwd_rs = wb_live && (ex_rs_regf == wb_regf);
    assign fwd_rt = wb_live && (ex_rt_regf == wb_regf);

    assign rs_value = fwd_rs ? wb_data : ex_rs_data;
    assign rt_value = fwd_rt ? wb_data : ex_rt_data;

    // An r0 operand reads zero whatever sits in writeback
    always_comb begin
        if (ex_rs_regf == '0) begin
            assert (rs_value == '0);
        end
        if (ex_rt_regf == '0) begin
            assert (rt_value == '0);
        end
    end

endmodule

// File: design/alu_unit.sv
`timescale 1ns/1ns

module alu_unit (
    input  mips_pkg::exec_info_t            in_data,
    input  logic [mips_pkg::data_width-1:0] rs_value,
    input  logic [mips_pkg::data_width-1:0] rt_value,
    output mips_pkg::retire_info_t          out_data
);

    import mips_pkg::*;

    logic [data_width-1:0] op_b;
    logic [data_width-1:0] result;
    logic                  less;

    assign op_b = in_data.sel_imme ? in_data.imme : rt_value;
    assign less = $signed(rs_value) < $signed(op_b);

    always_comb begin
        case (in_data.alu_op)
            alu_addu: result = rs_value + op_b;
            alu_subu: result = rs_value - op_b;
            alu_and:  result = rs_value & op_b;
            alu_or:   result = rs_value | op_b;
            alu_xor:  result = rs_value ^ op_b;
            alu_slt:  result = {{(data_width-1){1'b0}}, less};
            alu_sll:  result = rt_value << in_data.shamt; // rt, not op_b
            alu_lui:  result = {in_data.imme[15:0], 16'b0};
            default:  result = '0;
        endcase
    end

    always_comb begin
        out_data.pc      = in_data.pc;
        out_data.wen     = in_data.wen;
        out_data.rd_regf = in_data.rd_regf;
        out_data.result  = result;
    end

endmodule

// File: design/mips_core.sv
`timescale 1ns/1ns

module mips_core (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            instr_valid,
    input  logic [mips_pkg::data_width-1:0] instr_data,
    input  logic                            retire_ready,
    output logic                            instr_ready,
    output logic                            retire_valid,
    output logic [mips_pkg::data_width-1:0] retire_pc,
    output logic                            retire_wen,
    output logic [mips_pkg::regf_width-1:0] retire_regf,
    output logic [mips_pkg::data_width-1:0] retire_data
);

    import mips_pkg::*;

    // IF
    logic         if_valid;
    logic         if_ready;
    fetch_info_t  if_data;

    // ID
    logic                  id_valid;
    logic                  id_ready;
    fetch_info_t           id_data;
    exec_info_t            id_exec;
    logic [regf_width-1:0] rs_regf;
    logic [regf_width-1:0] rt_regf;
    logic [data_width-1:0] rs_data;
    logic [data_width-1:0] rt_data;

    // EX
    logic                  ex_valid;
    logic                  ex_ready;
    exec_info_t            ex_data;
    logic [data_width-1:0] ex_rs_value;
    logic [data_width-1:0] ex_rt_value;
    retire_info_t          ex_result;

    // WB
    retire_info_t wb_data;
    logic         wb_fire;

    fetch_unit fetch_0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_valid(instr_valid),
        .instr_data (instr_data),
        .out_ready  (if_ready),
        .instr_ready(instr_ready),
        .out_valid  (if_valid),
        .out_data   (if_data)
    );

    stage_buffer #(.payload_t(fetch_info_t)) f_d (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (if_valid),
        .in_data  (if_data),
        .out_ready(id_ready),
        .in_ready (if_ready),
        .out_valid(id_valid),
        .out_data (id_data)
    );

    decode_unit decode_0 (
        .in_data (id_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .rs_regf (rs_regf),
        .rt_regf (rt_regf),
        .out_data(id_exec)
    );

    reg_file regs_0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs_regf(rs_regf),
        .rt_regf(rt_regf),
        .wen    (wb_fire && wb_data.wen),
        .wr_regf(wb_data.rd_regf),
        .wr_data(wb_data.result),
        .rs_data(rs_data),
        .rt_data(rt_data)
    );

    stage_buffer #(.payload_t(exec_info_t)) d_e (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (id_valid),
        .in_data  (id_exec),
        .out_ready(ex_ready),
        .in_ready (id_ready),
        .out_valid(ex_valid),
        .out_data (ex_data)
    );

    forward_unit forward_0 (
        .ex_rs_regf(ex_data.rs_regf),
        .ex_rt_regf(ex_data.rt_regf),
        .ex_rs_data(ex_data.rs_data),
        .ex_rt_data(ex_data.rt_data),
        .wb_valid  (retire_valid),
        .wb_wen    (wb_data.wen),
        .wb_regf   (wb_data.rd_regf),
        .wb_data   (wb_data.result),
        .rs_value  (ex_rs_value),
        .rt_value  (ex_rt_value)
    );

    alu_unit alu_0 (
        .in_data (ex_data),
        .rs_value(ex_rs_value),
        .rt_value(ex_rt_value),
        .out_data(ex_result)
    );

    stage_buffer #(.payload_t(retire_info_t)) e_w (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (ex_valid),
        .in_data  (ex_result),
        .out_ready(retire_ready),
        .in_ready (ex_ready),
        .out_valid(retire_valid),
        .out_data (wb_data)
    );

    // Register write lands on the retire handshake
    assign wb_fire     = retire_valid && retire_ready;
    assign retire_pc   = wb_data.pc;
    assign retire_wen  = wb_data.wen;
    assign retire_regf = wb_data.rd_regf;
    assign retire_data = wb_data.result;

    no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && retire_wen |-> retire_regf != '0);

endmodule

// File: tb/tb_mips_core.sv
`timescale 1ns/1ns

module tb_mips_core;

    import mips_pkg::*;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  instr_valid;
    logic [data_width-1:0] instr_data;
    logic                  retire_ready;
    logic                  instr_ready;
    logic                  retire_valid;
    logic [data_width-1:0] retire_pc;
    logic                  retire_wen;
    logic [regf_width-1:0] retire_regf;
    logic [data_width-1:0] retire_data;

    string       test_name = "reset";
    logic [31:0] lfsr = 32'h9063315a;
    logic        drop_ready = 1'b0;
    logic [31:0] word_q[$];
    logic [31:0] pc_q[$];
    logic [31:0] model_regs [32];
    int          accept_count = 0;
    int          retire_count = 0;
    logic        head_valid = 1'b0;
    logic [31:0] head_pc;
    logic        head_wen;
    logic [4:0]  head_regf;
    logic [31:0] head_data;

    mips_core dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .retire_ready(retire_ready),
        .instr_ready (instr_ready),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_wen  (retire_wen),
        .retire_regf (retire_regf),
        .retire_data (retire_data)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch in %s: %s expected %h actual %h", test_name, what, expected, actual);
        $display("** FAIL **");
        $fatal(1, "retire check failed");
    endtask

    task automatic report_error(input string what);
        $display("Error in %s: %s", test_name, what);
        $display("** FAIL **");
        $fatal(1, "testbench check failed");
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] r_type_word(input logic [5:0] fn, input logic [4:0] rd,
                                                input logic [4:0] rs, input logic [4:0] rt,
                                                input logic [4:0] sa);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [5:0] op, input logic [4:0] rt,
                                                input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Expected outcome of one word against the current register model
    function automatic void predict(input logic [31:0] word, output logic wen,
                                    output logic [4:0] dest, output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        a     = model_regs[word[25:21]];
        b     = model_regs[word[20:16]];
        sext  = {{16{word[15]}}, word[15:0]};
        zext  = {16'h0, word[15:0]};
        wen   = 1'b1;
        dest  = word[20:16];
        value = '0;
        if (word[31:26] == op_special) begin
            dest = word[15:11];
            case (word[5:0])
                fn_addu: value = a + b;
                fn_subu: value = a - b;
                fn_and:  value = a & b;
                fn_or:   value = a | b;
                fn_xor:  value = a ^ b;
                fn_slt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                fn_sll:  value = b << word[10:6];
                default: wen = 1'b0;
            endcase
        end else begin
            case (word[31:26])
                op_addiu: value = a + sext;
                op_andi:  value = a & zext;
                op_ori:   value = a | zext;
                op_lui:   value = {word[15:0], 16'h0};
                default:  wen = 1'b0;
            endcase
        end
        if (dest == 5'd0) begin
            wen = 1'b0;
        end
    endfunction

    function automatic logic [31:0] random_word();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        logic [4:0]  sa;
        logic [31:0] word;
        kind = 4'(lfsr_take(4));
        rd   = 5'(lfsr_take(3)); // Few registers, many hazards
        rs   = 5'(lfsr_take(3));
        rt   = 5'(lfsr_take(3));
        imm  = 16'(lfsr_take(16));
        sa   = 5'(lfsr_take(5));
        case (kind)
            4'd0:    word = r_type_word(fn_addu, rd, rs, rt, 5'd0);
            4'd1:    word = r_type_word(fn_subu, rd, rs, rt, 5'd0);
            4'd2:    word = r_type_word(fn_and, rd, rs, rt, 5'd0);
            4'd3:    word = r_type_word(fn_or, rd, rs, rt, 5'd0);
            4'd4:    word = r_type_word(fn_xor, rd, rs, rt, 5'd0);
            4'd5:    word = r_type_word(fn_slt, rd, rs, rt, 5'd0);
            4'd6:    word = r_type_word(fn_sll, rd, 5'd0, rt, sa);
            4'd7:    word = i_type_word(op_addiu, rt, rs, imm);
            4'd8:    word = i_type_word(op_andi, rt, rs, imm);
            4'd9:    word = i_type_word(op_ori, rt, rs, imm);
            4'd10:   word = i_type_word(op_lui, rt, 5'd0, imm);
            4'd11:   word = i_type_word(6'h3f, rt, rs, imm); // Unknown opcode
            default: word = i_type_word(op_addiu, rt, rs, imm);
        endcase
        return word;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        retire_ready = drop_ready ? (lfsr_take(2) != 32'd0) : 1'b1;
    endtask

    task automatic send_word(input logic [31:0] word);
        int start;
        int waited;
        start       = accept_count;
        waited      = 0;
        instr_valid = 1'b1;
        instr_data  = word;
        while (accept_count == start) begin
            next_cycle();
            waited++;
            if (waited > 100) begin
                report_error("instruction word was never accepted");
            end
        end
        instr_valid = 1'b0;
        instr_data  = '0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (retire_count != accept_count) begin
            next_cycle();
            waited++;
            if (waited > 200) begin
                report_error("pipeline did not drain");
            end
        end
    endtask

    // Accept and retire bookkeeping plus reference register model
    always @(posedge clk) begin
        if (rst_n) begin
            if (retire_valid && retire_ready && head_valid) begin
                if (head_wen) begin
                    model_regs[head_regf] = head_data;
                end
                void'(word_q.pop_front());
                void'(pc_q.pop_front());
                retire_count++;
            end
            if (instr_valid && instr_ready) begin
                word_q.push_back(instr_data);
                pc_q.push_back(reset_pc + 32'(4 * accept_count));
                accept_count++;
            end
            head_valid = word_q.size() > 0;
            if (head_valid) begin
                head_pc = pc_q[0];
                predict(word_q[0], head_wen, head_regf, head_data);
            end
        end
    end

    reset_state: assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid && instr_ready)
        else report_error("retire_valid high or instr_ready low after reset");

    retire_known: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> head_valid)
        else report_error("retire port showed an instruction that was never accepted");

    pc_match: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && head_valid |-> retire_pc == head_pc)
        else report_mismatch("retire_pc", $sampled(head_pc), $sampled(retire_pc));

    wen_match: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && head_valid |-> retire_wen == head_wen)
        else report_mismatch("retire_wen", {31'b0, $sampled(head_wen)},
                             {31'b0, $sampled(retire_wen)});

    regf_match: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && head_valid && head_wen |-> retire_regf == head_regf)
        else report_mismatch("retire_regf", {27'b0, $sampled(head_regf)},
                             {27'b0, $sampled(retire_regf)});

    data_match: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && head_valid && head_wen |-> retire_data == head_data)
        else report_mismatch("retire_data", $sampled(head_data), $sampled(retire_data));

    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
            && $stable(retire_wen) && $stable(retire_regf) && $stable(retire_data))
        else report_error("retire fields changed while retire_ready was low");

    initial begin
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr_data   = '0;
        retire_ready = 1'b1;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_name = "alu_ops";
        send_word(i_type_word(op_lui, 5'd1, 5'd0, 16'h8000));
        send_word(i_type_word(op_ori, 5'd1, 5'd1, 16'h1234));
        send_word(i_type_word(op_addiu, 5'd2, 5'd0, 16'hfffb)); // -5
        send_word(i_type_word(op_andi, 5'd3, 5'd2, 16'hff00));
        send_word(i_type_word(op_ori, 5'd4, 5'd0, 16'h8001));
        send_word(r_type_word(fn_addu, 5'd5, 5'd1, 5'd2, 5'd0));
        send_word(r_type_word(fn_subu, 5'd6, 5'd4, 5'd2, 5'd0));
        send_word(r_type_word(fn_and, 5'd7, 5'd1, 5'd4, 5'd0));
        send_word(r_type_word(fn_or, 5'd8, 5'd1, 5'd3, 5'd0));
        send_word(r_type_word(fn_xor, 5'd9, 5'd2, 5'd4, 5'd0));
        send_word(r_type_word(fn_slt, 5'd10, 5'd2, 5'd4, 5'd0));
        send_word(r_type_word(fn_slt, 5'd11, 5'd4, 5'd2, 5'd0));
        send_word(r_type_word(fn_sll, 5'd12, 5'd0, 5'd4, 5'd17));
        drain();

        // Distance one hits forwarding, distance two the write-through
        test_name = "dependent_chain";
        for (int i = 0; i < 6; i++) begin
            send_word(i_type_word(op_addiu, 5'd13, 5'd13, 16'h0101));
            send_word(r_type_word(fn_addu, 5'd14, 5'd13, 5'd14, 5'd0));
            send_word(r_type_word(fn_xor, 5'd15, 5'd14, 5'd13, 5'd0));
        end
        drain();

        test_name = "zero_register";
        send_word(i_type_word(op_ori, 5'd18, 5'd0, 16'h5555));
        send_word(i_type_word(op_addiu, 5'd0, 5'd1, 16'h0077));
        send_word(r_type_word(fn_or, 5'd0, 5'd1, 5'd2, 5'd0));
        send_word(i_type_word(6'h3f, 5'd16, 5'd1, 16'h1234));
        send_word(r_type_word(6'h3f, 5'd17, 5'd1, 5'd2, 5'd0)); // Unknown funct
        send_word(r_type_word(fn_addu, 5'd18, 5'd0, 5'd0, 5'd0));
        send_word(r_type_word(fn_or, 5'd19, 5'd0, 5'd1, 5'd0));
        send_word(r_type_word(fn_or, 5'd20, 5'd16, 5'd17, 5'd0));
        drain();

        test_name  = "random_traffic";
        drop_ready = 1'b1;
        for (int n = 0; n < 400; n++) begin
            send_word(random_word());
            if (lfsr_take(2) == 32'd0) begin
                repeat (int'(lfsr_take(2)) + 1) next_cycle();
            end
        end
        drop_ready = 1'b0;
        drain();

        // Each register read back through the retire port
        test_name = "final_state";
        for (int i = 1; i < 32; i++) begin
            send_word(r_type_word(fn_addu, 5'(i), 5'(i), 5'd0, 5'd0));
        end
        drain();
        if (!retire_valid) begin
            $display("** PASS **");
            $finish;
        end else begin
            report_error("retire port still valid after every instruction retired");
        end
    end

endmodule

// File: build.f
design/mips_pkg.sv
design/stage_buffer.sv
design/fetch_unit.sv
design/decode_unit.sv
design/reg_file.sv
design/forward_unit.sv
design/alu_unit.sv
design/mips_core.sv
tb/tb_mips_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mips_core
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
